/* source/glay_pkg.sv */
// ----------------------------------------------------------
// Request cluster package
// Lane count, packet widths, FIFO sizing and engine opcodes
// shared by the packer, the demux and the engine lanes
// ----------------------------------------------------------

package glay_pkg;

  // ----------------------------------------------------------
  // Cluster sizing
  // ----------------------------------------------------------
  // Engine lanes, also the width of every destination mask
  localparam int num_lanes = 4;

  // Command data and lane accumulator width
  localparam int data_width = 32;

  // Sequence tag stamped on every forwarded packet
  localparam int tag_width = 8;

  // ----------------------------------------------------------
  // Demux buffering
  // ----------------------------------------------------------
  localparam int fifo_depth = 16;

  // Leaves 4 free entries for packets still in flight
  localparam int prog_full_thresh = 12;

  // ----------------------------------------------------------
  // Engine opcodes
  // ----------------------------------------------------------
  // Codes 0, 5, 6 and 7 are rejected by the packer
  typedef enum logic [2:0] {
    op_add   = 3'd1,
    op_min   = 3'd2,
    op_max   = 3'd3,
    op_clear = 3'd4
  } opcode_t;

  localparam int opcode_width = $bits(opcode_t);

  // FIFO word is {opcode, mask, tag, data}
  localparam int packet_width = opcode_width + num_lanes + tag_width + data_width;

endpackage : glay_pkg

/* source/request_fifo.sv */
// ----------------------------------------------------------
// Request FIFO
// Synchronous first-word-fall-through circular buffer with
// full, empty and programmable-full flags
// ----------------------------------------------------------

`timescale 1ns/1ns

module request_fifo #(
  parameter int depth = glay_pkg::fifo_depth
) (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              wr_en,
  input  logic [glay_pkg::packet_width-1:0] din,
  input  logic                              rd_en,
  output logic [glay_pkg::packet_width-1:0] dout,
  output logic                              full,
  output logic                              empty,
  output logic                              prog_full
);

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = ptr_w + 1;

  logic [glay_pkg::packet_width-1:0] mem [depth];
  logic [ptr_w-1:0]                  wr_ptr;
  logic [ptr_w-1:0]                  rd_ptr;
  logic [cnt_w-1:0]                  count;
  logic                              do_wr;
  logic                              do_rd;

  // Writes while full and reads while empty are dropped
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  assign full      = (count == cnt_w'(depth));
  assign empty     = (count == '0);
  assign prog_full = (count >= cnt_w'(glay_pkg::prog_full_thresh));

  // Head entry shows without a read request
  assign dout = mem[rd_ptr];

  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap on their own for a power of two depth
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : request_fifo

/* source/request_packer.sv */
// ----------------------------------------------------------
// Request packer
// Checks incoming commands, stamps a sequence tag on each
// valid one and forwards it as a single cycle packet pulse.
// Rejected commands are counted. Back-pressure follows the
// demux programmable-full flag
// ----------------------------------------------------------

`timescale 1ns/1ns

module request_packer (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  logic                                 cmd_valid,
  input  logic [2:0]                           cmd_opcode,
  input  logic [glay_pkg::num_lanes-1:0]       cmd_mask,
  input  logic [glay_pkg::data_width-1:0]      cmd_data,
  output logic                                 cmd_ready,
  input  logic                                 buf_prog_full,
  output logic                                 pkt_valid,
  output glay_pkg::opcode_t                    pkt_opcode,
  output logic [glay_pkg::num_lanes-1:0]       pkt_mask,
  output logic [glay_pkg::tag_width-1:0]       pkt_tag,
  output logic [glay_pkg::data_width-1:0]      pkt_data,
  output logic [15:0]                          drop_count
);

  logic                           cmd_accept;
  logic                           opcode_ok;
  logic                           cmd_ok;
  logic [glay_pkg::tag_width-1:0] tag_count;

  // Stop taking commands while the buffer is close to full
  assign cmd_ready  = ~buf_prog_full;
  assign cmd_accept = cmd_valid & cmd_ready;

  always_comb begin
    case (cmd_opcode)
      glay_pkg::op_add,
      glay_pkg::op_min,
      glay_pkg::op_max,
      glay_pkg::op_clear: opcode_ok = 1'b1;
      default:            opcode_ok = 1'b0;
    endcase
  end

  // A packet needs a known opcode and at least one lane
  assign cmd_ok = opcode_ok & (|cmd_mask);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pkt_valid  <= 1'b0;
      tag_count  <= '0;
      drop_count <= '0;
    end else begin
      pkt_valid <= cmd_accept & cmd_ok;
      if (cmd_accept && cmd_ok) begin
        tag_count <= tag_count + 1'b1;
      end
      if (cmd_accept && !cmd_ok) begin
        drop_count <= drop_count + 16'd1;
      end
    end
  end

  // Packet payload
  always_ff @(posedge ap_clk) begin
    pkt_opcode <= glay_pkg::opcode_t'(cmd_opcode);
    pkt_mask   <= cmd_mask;
    pkt_tag    <= tag_count;
    pkt_data   <= cmd_data;
  end

endmodule : request_packer

/* source/request_demux.sv */
// ----------------------------------------------------------
// Request demux
// Buffers engine packets and delivers each head packet to
// every lane in its destination mask at once. The head only
// leaves when all addressed lanes report ready, so order is
// strictly first in, first out
// ----------------------------------------------------------

`timescale 1ns/1ns

module request_demux (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  logic                            pkt_valid,
  input  glay_pkg::opcode_t               pkt_opcode,
  input  logic [glay_pkg::num_lanes-1:0]  pkt_mask,
  input  logic [glay_pkg::tag_width-1:0]  pkt_tag,
  input  logic [glay_pkg::data_width-1:0] pkt_data,
  output logic                            buf_prog_full,
  input  logic [glay_pkg::num_lanes-1:0]  lane_ready,
  output logic [glay_pkg::num_lanes-1:0]  lane_valid,
  output glay_pkg::opcode_t               lane_opcode,
  output logic [glay_pkg::tag_width-1:0]  lane_tag,
  output logic [glay_pkg::data_width-1:0] lane_data
);

  // ----------------------------------------------------------
  // Input register
  // ----------------------------------------------------------
  logic                            in_valid;
  glay_pkg::opcode_t               in_opcode;
  logic [glay_pkg::num_lanes-1:0]  in_mask;
  logic [glay_pkg::tag_width-1:0]  in_tag;
  logic [glay_pkg::data_width-1:0] in_data;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid <= 1'b0;
    end else begin
      in_valid <= pkt_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_opcode <= pkt_opcode;
    in_mask   <= pkt_mask;
    in_tag    <= pkt_tag;
    in_data   <= pkt_data;
  end

  // ----------------------------------------------------------
  // Packet FIFO
  // ----------------------------------------------------------
  logic                              fifo_wr_en;
  logic                              fifo_rd_en;
  logic [glay_pkg::packet_width-1:0] fifo_din;
  logic [glay_pkg::packet_width-1:0] fifo_dout;
  logic                              fifo_full;
  logic                              fifo_empty;
  logic                              fifo_prog_full;

  // Packets without a destination never enter the queue
  assign fifo_wr_en = in_valid & (|in_mask) & ~fifo_full;
  assign fifo_din   = {in_opcode, in_mask, in_tag, in_data};

  request_fifo #(
    .depth(glay_pkg::fifo_depth)
  ) i_request_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (fifo_wr_en),
    .din           (fifo_din),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .full          (fifo_full),
    .empty         (fifo_empty),
    .prog_full     (fifo_prog_full)
  );

  // ----------------------------------------------------------
  // Pop control
  // ----------------------------------------------------------
  logic [2:0]                      head_opcode;
  logic [glay_pkg::num_lanes-1:0]  head_mask;
  logic [glay_pkg::tag_width-1:0]  head_tag;
  logic [glay_pkg::data_width-1:0] head_data;
  logic [glay_pkg::num_lanes-1:0]  ready_reg;
  logic [glay_pkg::num_lanes-1:0]  ready_masked;

  assign {head_opcode, head_mask, head_tag, head_data} = fifo_dout;

  // Lanes outside the head's mask do not hold it back
  assign ready_masked = ready_reg & head_mask;
  assign fifo_rd_en   = ~fifo_empty & (ready_masked == head_mask);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_reg     <= '0;
      buf_prog_full <= 1'b0;
    end else begin
      ready_reg     <= lane_ready;
      buf_prog_full <= fifo_prog_full;
    end
  end

  // ----------------------------------------------------------
  // Output stage, pop to lane_valid in two cycles
  // ----------------------------------------------------------
  logic                            dout_valid;
  glay_pkg::opcode_t               dout_opcode;
  logic [glay_pkg::num_lanes-1:0]  dout_mask;
  logic [glay_pkg::tag_width-1:0]  dout_tag;
  logic [glay_pkg::data_width-1:0] dout_data;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      dout_valid <= 1'b0;
      lane_valid <= '0;
    end else begin
      dout_valid <= fifo_rd_en;
      lane_valid <= dout_mask & {glay_pkg::num_lanes{dout_valid}};
    end
  end

  always_ff @(posedge ap_clk) begin
    dout_opcode <= glay_pkg::opcode_t'(head_opcode);
    dout_mask   <= head_mask;
    dout_tag    <= head_tag;
    dout_data   <= head_data;
    lane_opcode <= dout_opcode;
    lane_tag    <= dout_tag;
    lane_data   <= dout_data;
  end

endmodule : request_demux

/* source/engine_lane.sv */
// ----------------------------------------------------------
// Engine lane
// Applies packet opcodes to a lane accumulator and reports
// each executed packet with its tag one cycle later
// ----------------------------------------------------------

`timescale 1ns/1ns

module engine_lane (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  logic                            lane_stall,
  output logic                            lane_ready,
  input  logic                            lane_valid,
  input  glay_pkg::opcode_t               lane_opcode,
  input  logic [glay_pkg::tag_width-1:0]  lane_tag,
  input  logic [glay_pkg::data_width-1:0] lane_data,
  output logic [glay_pkg::data_width-1:0] acc,
  output logic                            lane_done,
  output logic [glay_pkg::tag_width-1:0]  lane_tag_out
);

  logic [glay_pkg::data_width-1:0] acc_next;

  // Ready drops one cycle after a stall request
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      lane_ready <= 1'b1;
    end else begin
      lane_ready <= ~lane_stall;
    end
  end

  // ----------------------------------------------------------
  // Opcode execution
  // ----------------------------------------------------------
  // Min and max compare unsigned
  always_comb begin
    case (lane_opcode)
      glay_pkg::op_add:   acc_next = acc + lane_data;
      glay_pkg::op_min:   acc_next = (lane_data < acc) ? lane_data : acc;
      glay_pkg::op_max:   acc_next = (lane_data > acc) ? lane_data : acc;
      glay_pkg::op_clear: acc_next = lane_data;
      default:            acc_next = acc;
    endcase
  end

  // Packets are taken even while stalled
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      acc       <= '0;
      lane_done <= 1'b0;
    end else begin
      lane_done <= lane_valid;
      if (lane_valid) begin
        acc <= acc_next;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    lane_tag_out <= lane_tag;
  end

endmodule : engine_lane

/* source/request_cluster_top.sv */
// ----------------------------------------------------------
// Request cluster top
// Packer feeding the demux, which fans packets out to four
// engine lanes. Per-lane outputs are flattened
// ----------------------------------------------------------

`timescale 1ns/1ns

module request_cluster_top (
  input  logic                                                ap_clk,
  input  logic                                                areset_control,
  input  logic                                                cmd_valid,
  input  logic [2:0]                                          cmd_opcode,
  input  logic [glay_pkg::num_lanes-1:0]                      cmd_mask,
  input  logic [glay_pkg::data_width-1:0]                     cmd_data,
  output logic                                                cmd_ready,
  input  logic [glay_pkg::num_lanes-1:0]                      lane_stall,
  output logic [glay_pkg::num_lanes*glay_pkg::data_width-1:0] acc_out,
  output logic [glay_pkg::num_lanes-1:0]                      lane_done,
  output logic [glay_pkg::num_lanes*glay_pkg::tag_width-1:0]  lane_tag_out,
  output logic [15:0]                                         drop_count
);

  logic                            buf_prog_full;
  logic                            pkt_valid;
  glay_pkg::opcode_t               pkt_opcode;
  logic [glay_pkg::num_lanes-1:0]  pkt_mask;
  logic [glay_pkg::tag_width-1:0]  pkt_tag;
  logic [glay_pkg::data_width-1:0] pkt_data;
  logic [glay_pkg::num_lanes-1:0]  lane_ready;
  logic [glay_pkg::num_lanes-1:0]  lane_valid;
  glay_pkg::opcode_t               lane_opcode;
  logic [glay_pkg::tag_width-1:0]  lane_tag;
  logic [glay_pkg::data_width-1:0] lane_data;

  request_packer i_request_packer (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .cmd_valid     (cmd_valid),
    .cmd_opcode    (cmd_opcode),
    .cmd_mask      (cmd_mask),
    .cmd_data      (cmd_data),
    .cmd_ready     (cmd_ready),
    .buf_prog_full (buf_prog_full),
    .pkt_valid     (pkt_valid),
    .pkt_opcode    (pkt_opcode),
    .pkt_mask      (pkt_mask),
    .pkt_tag       (pkt_tag),
    .pkt_data      (pkt_data),
    .drop_count    (drop_count)
  );

  request_demux i_request_demux (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .pkt_valid     (pkt_valid),
    .pkt_opcode    (pkt_opcode),
    .pkt_mask      (pkt_mask),
    .pkt_tag       (pkt_tag),
    .pkt_data      (pkt_data),
    .buf_prog_full (buf_prog_full),
    .lane_ready    (lane_ready),
    .lane_valid    (lane_valid),
    .lane_opcode   (lane_opcode),
    .lane_tag      (lane_tag),
    .lane_data     (lane_data)
  );

  // Lanes share the payload bus and differ only in valid
  for (genvar i = 0; i < glay_pkg::num_lanes; i++) begin : g_lane
    engine_lane i_engine_lane (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .lane_stall    (lane_stall[i]),
      .lane_ready    (lane_ready[i]),
      .lane_valid    (lane_valid[i]),
      .lane_opcode   (lane_opcode),
      .lane_tag      (lane_tag),
      .lane_data     (lane_data),
      .acc           (acc_out[i*glay_pkg::data_width +: glay_pkg::data_width]),
      .lane_done     (lane_done[i]),
      .lane_tag_out  (lane_tag_out[i*glay_pkg::tag_width +: glay_pkg::tag_width])
    );
  end

endmodule : request_cluster_top

/* dv/request_cluster_tb.sv */
// ----------------------------------------------------------
// Request cluster testbench
// Drives unicast, multicast, dropped and back-pressured
// commands and checks every lane completion against a
// reference model of tags and accumulators
// ----------------------------------------------------------

`timescale 1ns/1ns

module request_cluster_tb;

  localparam int nl = glay_pkg::num_lanes;
  localparam int dw = glay_pkg::data_width;
  localparam int tw = glay_pkg::tag_width;
  localparam int n_unicast = 60;
  localparam int n_multicast = 30;
  localparam int n_drop = 20;
  localparam int n_stall = 40;
  localparam int n_cmds = n_unicast + n_multicast + n_drop + n_stall;

  logic             ap_clk;
  logic             areset_control;
  logic             cmd_valid;
  logic [2:0]       cmd_opcode;
  logic [nl-1:0]    cmd_mask;
  logic [dw-1:0]    cmd_data;
  logic             cmd_ready;
  logic [nl-1:0]    lane_stall;
  logic [nl*dw-1:0] acc_out;
  logic [nl-1:0]    lane_done;
  logic [nl*tw-1:0] lane_tag_out;
  logic [15:0]      drop_count;

  // Reference model state
  logic [dw-1:0] model_acc [nl] = '{default: '0};
  logic [tw-1:0] tag_model = '0;
  logic [15:0]   drop_model = '0;
  logic [tw-1:0] tag_q [nl][$];
  logic [dw-1:0] acc_q [nl][$];
  logic [nl-1:0] mask_q [nl][$];
  logic          exp_pending [nl];
  logic [tw-1:0] exp_tag [nl];
  logic [dw-1:0] exp_acc [nl];
  logic [nl-1:0] exp_mask [nl];
  logic          saw_backpressure = 1'b0;

  request_cluster_top i_request_cluster_top (.*);

  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at the first failing check");
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    report_failure($sformatf("error %0t %s got 0x%0h expected 0x%0h",
                             $time, name, got, exp));
  endtask

  function automatic logic [dw-1:0] apply_op(input logic [2:0] op, input logic [dw-1:0] a,
                                             input logic [dw-1:0] d);
    case (op)
      glay_pkg::op_add:   return a + d;
      glay_pkg::op_min:   return (d < a) ? d : a;
      glay_pkg::op_max:   return (d > a) ? d : a;
      default:            return d;
    endcase
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int i = 0; i < nl; i++) n += tag_q[i].size();
    return n;
  endfunction

  // ----------------------------------------------------------
  // Reference model updated on accept and on completion
  // ----------------------------------------------------------
  always @(posedge ap_clk) begin
    if (!areset_control && cmd_valid && cmd_ready) begin
      if (cmd_opcode inside {[3'd1:3'd4]} && cmd_mask != '0) begin
        for (int i = 0; i < nl; i++) begin
          if (cmd_mask[i]) begin
            model_acc[i] = apply_op(cmd_opcode, model_acc[i], cmd_data);
            tag_q[i].push_back(tag_model);
            acc_q[i].push_back(model_acc[i]);
            mask_q[i].push_back(cmd_mask);
          end
        end
        tag_model = tag_model + 8'd1;
      end else begin
        drop_model <= drop_model + 16'd1;
      end
    end
    for (int i = 0; i < nl; i++) begin
      if (!areset_control && lane_done[i] && tag_q[i].size() > 0) begin
        void'(tag_q[i].pop_front());
        void'(acc_q[i].pop_front());
        void'(mask_q[i].pop_front());
      end
      exp_pending[i] = tag_q[i].size() > 0;
      exp_tag[i]     = exp_pending[i] ? tag_q[i][0] : '0;
      exp_acc[i]     = exp_pending[i] ? acc_q[i][0] : '0;
      exp_mask[i]    = exp_pending[i] ? mask_q[i][0] : '0;
    end
  end

  // ----------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------
  for (genvar i = 0; i < nl; i++) begin : g_check
    assert property (@(posedge ap_clk) disable iff (areset_control)
      lane_done[i] |-> exp_pending[i])
      else report_failure($sformatf("lane %0d completed with no packet expected", i));
    assert property (@(posedge ap_clk) disable iff (areset_control)
      lane_done[i] |-> lane_tag_out[i*tw +: tw] == exp_tag[i])
      else report_value($sformatf("lane_tag_out[%0d]", i),
                        32'($sampled(lane_tag_out[i*tw +: tw])), 32'($sampled(exp_tag[i])));
    assert property (@(posedge ap_clk) disable iff (areset_control)
      lane_done[i] |-> acc_out[i*dw +: dw] == exp_acc[i])
      else report_value($sformatf("acc_out[%0d]", i),
                        $sampled(acc_out[i*dw +: dw]), $sampled(exp_acc[i]));
    // A multicast completes on all its lanes together and nowhere else
    assert property (@(posedge ap_clk) disable iff (areset_control)
      lane_done[i] |-> lane_done == exp_mask[i])
      else report_value("lane_done", 32'($sampled(lane_done)), 32'($sampled(exp_mask[i])));
  end

  assert property (@(posedge ap_clk) disable iff (areset_control) drop_count == drop_model)
    else report_value("drop_count", 32'($sampled(drop_count)), 32'($sampled(drop_model)));

  assert property (@(posedge ap_clk) disable iff (areset_control)
    !(i_request_cluster_top.i_request_demux.in_valid &&
      i_request_cluster_top.i_request_demux.fifo_full))
    else report_failure("a packet reached the full demux FIFO and was lost");

  // ----------------------------------------------------------
  // Stimulus helpers called on a falling edge
  // ----------------------------------------------------------
  task automatic send_cmd(input logic [2:0] op, input logic [nl-1:0] mask,
                          input logic [dw-1:0] data);
    cmd_valid  = 1'b1;
    cmd_opcode = op;
    cmd_mask   = mask;
    cmd_data   = data;
    while (!cmd_ready) @(negedge ap_clk);
    @(negedge ap_clk);
    cmd_valid = 1'b0;
  endtask

  function automatic logic [nl-1:0] multicast_mask();
    logic [nl-1:0] m;
    do m = 4'($urandom); while ($countones(m) < 2);
    return m;
  endfunction

  // Gives one of the unused codes 0, 5, 6 or 7
  function automatic logic [2:0] invalid_op();
    logic [2:0] op;
    op = 3'($urandom_range(3, 0));
    return (op == 3'd0) ? op : op + 3'd4;
  endfunction

  task automatic drain_and_check();
    while (pending_total() != 0) @(negedge ap_clk);
    repeat (4) @(negedge ap_clk);
    for (int i = 0; i < nl; i++) begin
      assert (acc_out[i*dw +: dw] == model_acc[i])
        else report_value($sformatf("acc_out[%0d]", i), acc_out[i*dw +: dw], model_acc[i]);
    end
  endtask

  initial begin
    repeat (n_cmds * 40 + 2000) @(posedge ap_clk);
    report_failure("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    void'($urandom(23));
    areset_control = 1'b1;
    cmd_valid      = 1'b0;
    cmd_opcode     = '0;
    cmd_mask       = '0;
    cmd_data       = '0;
    lane_stall     = '0;
    repeat (5) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_control = 1'b0;
    @(negedge ap_clk);

    assert (cmd_ready == 1'b1) else report_value("cmd_ready", 32'(cmd_ready), 32'd1);
    assert (lane_done == '0) else report_value("lane_done", 32'(lane_done), 32'd0);
    assert (drop_count == '0) else report_value("drop_count", 32'(drop_count), 32'd0);
    drain_and_check();

    repeat (n_unicast) send_cmd(3'($urandom_range(4, 1)), 4'b0001 << $urandom_range(3, 0),
                                $urandom);
    drain_and_check();
    repeat (n_multicast) send_cmd(3'($urandom_range(4, 1)), multicast_mask(), $urandom);
    drain_and_check();
    for (int k = 0; k < n_drop; k++) begin
      if (k % 2 == 0) send_cmd(3'($urandom_range(4, 1)), '0, $urandom);
      else send_cmd(invalid_op(), 4'($urandom_range(15, 1)), $urandom);
    end
    drain_and_check();

    // Lane 2 stalled while every command targets it
    lane_stall = 4'b0100;
    fork
      repeat (n_stall) send_cmd(3'($urandom_range(4, 1)), 4'($urandom) | 4'b0100, $urandom);
      begin
        for (int c = 0; c < 400 && cmd_ready; c++) @(negedge ap_clk);
        saw_backpressure = !cmd_ready;
        repeat (30) @(negedge ap_clk);
        lane_stall = '0;
      end
    join
    assert (saw_backpressure) else report_failure("cmd_ready never fell during the lane stall");
    drain_and_check();

    $display("RESULT: PASS");
    $finish;
  end

endmodule : request_cluster_tb

/* request_cluster_top.f */
source/glay_pkg.sv
source/request_fifo.sv
source/request_packer.sv
source/request_demux.sv
source/engine_lane.sv
source/request_cluster_top.sv
dv/request_cluster_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: run lint clean

run: obj_dir/Vrequest_cluster_tb
	./obj_dir/Vrequest_cluster_tb | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

obj_dir/Vrequest_cluster_tb: request_cluster_top.f source/*.sv dv/*.sv
	verilator --binary --assert --timing --top-module request_cluster_tb -f request_cluster_top.f

lint:
	verilator --lint-only --assert --timing --top-module request_cluster_tb -f request_cluster_top.f

clean:
	rm -rf obj_dir $(LOG)
